/* src.f */
+incdir+include
source/core_types_pkg.sv
source/core_ctrl_pkg.sv
source/mux_key.sv
source/register_file.sv
source/inst_decoder.sv
source/alu.sv
source/cycle_counter.sv
source/core_fsm.sv
source/rv_core_top.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f src.f --top-module tb_rv_core -o sim_rv_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# keep running after an assertion error so the testbench reports the result
./obj_dir/sim_rv_core +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* test/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int          NUM_TESTS    = 9;
  localparam int          MEM_WORDS    = 64;
  localparam int          RESET_CYCLES = 4;
  localparam logic [31:0] SEED         = 32'h1abc_1d24;

  localparam core_types_pkg::inst_t EBREAK = 32'h0010_0073;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_UNKNOWN = 7'b1111111;
  localparam logic [4:0] X0 = 5'd0;
  localparam logic [4:0] T0 = 5'd5;
  localparam logic [4:0] T1 = 5'd6;
  localparam logic [4:0] A0 = 5'd10;

  // program lengths in run order
  localparam int PROG_LENS [NUM_TESTS] = '{7, 6, 6, 6, 6, 6, 5, 3, 4};

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  start;
  core_types_pkg::inst_t imem_data;
  core_types_pkg::pc_t   imem_addr;
  logic                  halted;
  core_types_pkg::xlen_t a0;
  core_types_pkg::cnt_t  cycles;
  core_types_pkg::cnt_t  instret;

  core_types_pkg::inst_t prog [MEM_WORDS];
  int   prog_len = 0;
  int   errors = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   cycle_cnt = 0;
  int   cycle_limit = 0;
  logic test_ok;

  always #5 clk = ~clk;

  rv_core_top DUT (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .halted    (halted),
    .a0        (a0),
    .cycles    (cycles),
    .instret   (instret)
  );

  bind rv_core_top rv_core_sva u_sva (
    .clk    (clk),
    .rst    (rst),
    .halted (halted),
    .wb_en  (wb_en),
    .retire (retire),
    .state  (u_fsm.state),
    .pc     (imem_addr)
  );

  // combinational instruction memory that returns ebreak past the program end
  always_comb begin
    core_types_pkg::pc_t word_idx;
    word_idx = imem_addr >> 2;
    if (word_idx < core_types_pkg::pc_t'(prog_len)) begin
      imem_data = prog[word_idx[5:0]];
    end else begin
      imem_data = EBREAK;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic int timeout_cycles();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      sum += 3 * (PROG_LENS[i] + 10);
    end
    return sum;
  endfunction

  function automatic core_types_pkg::inst_t enc_addi(logic [4:0] rd, logic [4:0] rs1,
                                                     logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
  endfunction

  function automatic core_types_pkg::inst_t enc_rr(logic [6:0] funct7, logic [2:0] funct3,
                                                   logic [4:0] rd, logic [4:0] rs1,
                                                   logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, OPC_OP};
  endfunction

  function automatic core_types_pkg::inst_t enc_lui(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [11:0] rand_imm12();
    return 12'($urandom);
  endfunction

  function automatic logic [19:0] rand_imm20();
    return 20'($urandom);
  endfunction

  task automatic clear_prog();
    prog_len = 0;
  endtask

  task automatic push_inst(input core_types_pkg::inst_t word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  // ISA-level model of the supported subset where anything else is a no-op
  task automatic reference_run(output core_types_pkg::xlen_t exp_a0, output int n_exec);
    core_types_pkg::xlen_t regs [32];
    core_types_pkg::xlen_t a;
    core_types_pkg::xlen_t b;
    core_types_pkg::xlen_t res;
    core_types_pkg::inst_t w;
    logic                  wr;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    n_exec = 0;
    for (int i = 0; i < prog_len; i++) begin
      w = prog[i];
      n_exec++;
      if (w == EBREAK) begin
        break;
      end
      a   = regs[w[19:15]];
      b   = regs[w[24:20]];
      wr  = 1'b1;
      res = '0;
      if (w[6:0] == OPC_OP_IMM && w[14:12] == 3'b000) begin
        res = a + {{52{w[31]}}, w[31:20]};
      end else if (w[6:0] == OPC_OP) begin
        case ({w[31:25], w[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_111: res = a & b;
          10'b0000000_110: res = a | b;
          10'b0000000_100: res = a ^ b;
          default:         wr = 1'b0;
        endcase
      end else if (w[6:0] == OPC_LUI) begin
        res = {{32{w[31]}}, w[31:12], 12'h000};
      end else begin
        wr = 1'b0;
      end
      if (wr && w[11:7] != X0) begin
        regs[w[11:7]] = res;
      end
    end
    exp_a0 = regs[A0];
  endtask

  task automatic check_value(input string name, input string what,
                             input core_types_pkg::xlen_t exp, input core_types_pkg::xlen_t act);
    assert (act === exp) else begin
      $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic run_program(input string name);
    core_types_pkg::xlen_t exp_a0;
    int                    n_exec;
    @(negedge clk);
    rst   = 1'b1;
    start = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst   = 1'b0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    do @(negedge clk); while (halted !== 1'b1);
    reference_run(exp_a0, n_exec);
    test_ok = 1'b1;
    check_value(name, "a0", exp_a0, a0);
    check_value(name, "instret", core_types_pkg::xlen_t'(n_exec),
                core_types_pkg::xlen_t'(instret));
    check_value(name, "cycles", core_types_pkg::xlen_t'(3 * (n_exec - 1) + 2),
                core_types_pkg::xlen_t'(cycles));
    // ebreak never reaches WB so the pc stays on its address
    check_value(name, "pc", core_types_pkg::xlen_t'(4 * (n_exec - 1)), imem_addr);
    tests_run++;
    if (test_ok) begin
      $display("test %s finished ok", name);
    end else begin
      tests_failed++;
      $display("test %s finished with errors", name);
    end
  endtask

  task automatic test_addi_chain();
    clear_prog();
    push_inst(enc_addi(A0, X0, rand_imm12()));
    for (int i = 0; i < 5; i++) begin
      push_inst(enc_addi(A0, A0, rand_imm12()));
    end
    push_inst(EBREAK);
    run_program("addi_chain");
  endtask

  // operands built from lui and addi so the upper bits vary too
  task automatic test_reg_op(input string name, input logic [6:0] funct7,
                             input logic [2:0] funct3);
    clear_prog();
    push_inst(enc_lui(T0, rand_imm20()));
    push_inst(enc_addi(T0, T0, rand_imm12()));
    push_inst(enc_lui(T1, rand_imm20()));
    push_inst(enc_addi(T1, T1, rand_imm12()));
    push_inst(enc_rr(funct7, funct3, A0, T0, T1));
    push_inst(EBREAK);
    run_program(name);
  endtask

  task automatic test_x0_write();
    clear_prog();
    push_inst(enc_addi(A0, X0, rand_imm12()));
    push_inst(enc_addi(X0, X0, rand_imm12()));
    push_inst(enc_rr(7'b0000000, 3'b000, X0, A0, A0));
    push_inst(enc_rr(7'b0000000, 3'b000, A0, A0, X0));
    push_inst(EBREAK);
    run_program("x0_write");
  endtask

  task automatic test_lui_addi();
    clear_prog();
    // top bit set so the constant sign-extends to 64 bits
    push_inst(enc_lui(A0, rand_imm20() | 20'h80000));
    push_inst(enc_addi(A0, A0, rand_imm12()));
    push_inst(EBREAK);
    run_program("lui_addi");
  endtask

  task automatic test_unknown_op();
    clear_prog();
    push_inst(enc_addi(A0, X0, rand_imm12()));
    push_inst({rand_imm20(), A0, OPC_UNKNOWN});
    push_inst(enc_addi(A0, A0, 12'd1));
    push_inst(EBREAK);
    run_program("unknown_op");
  endtask

  initial begin
    rst   = 1'b1;
    start = 1'b0;
    void'($urandom(SEED));
    cycle_limit = timeout_cycles();
    test_addi_chain();
    test_reg_op("reg_add", 7'b0000000, 3'b000);
    test_reg_op("reg_sub", 7'b0100000, 3'b000);
    test_reg_op("reg_and", 7'b0000000, 3'b111);
    test_reg_op("reg_or", 7'b0000000, 3'b110);
    test_reg_op("reg_xor", 7'b0000000, 3'b100);
    test_x0_write();
    test_lui_addi();
    test_unknown_op();
    $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, DUT.u_sva.fail_count);
    if (errors == 0 && DUT.u_sva.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/rv_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva (
  input logic                      clk,
  input logic                      rst,
  input logic                      halted,
  input logic                      wb_en,
  input logic                      retire,
  input core_ctrl_pkg::fsm_state_t state,
  input core_types_pkg::pc_t       pc
);

  // number of failed assertions
  int unsigned fail_count = 0;

  // halt is left only through reset
  halted_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else begin
      $error("halted dropped without a reset");
      fail_count++;
    end

  // writeback only ever follows an execute cycle
  wb_en_in_wb: assert property (@(posedge clk) disable iff (rst)
    wb_en |-> ($past(state) == core_ctrl_pkg::S_EXEC))
    else begin
      $error("wb_en high without an execute cycle before it");
      fail_count++;
    end

  pc_moves_in_wb: assert property (@(posedge clk) disable iff (rst)
    (state != core_ctrl_pkg::S_WB) |=> $stable(pc))
    else begin
      $error("pc changed outside the writeback state");
      fail_count++;
    end

  // at least one FETCH cycle between retirements
  retire_single: assert property (@(posedge clk) disable iff (rst) retire |=> !retire)
    else begin
      $error("retire high on two cycles in a row");
      fail_count++;
    end

endmodule

`default_nettype wire

/* source/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  core_types_pkg::inst_t imem_data,
  output core_types_pkg::pc_t   imem_addr,
  output logic                  halted,
  output core_types_pkg::xlen_t a0,
  output core_types_pkg::cnt_t  cycles,
  output core_types_pkg::cnt_t  instret
);

  core_types_pkg::inst_t inst;
  core_ctrl_pkg::dec_t   dec;
  core_types_pkg::xlen_t rs1_val;
  core_types_pkg::xlen_t rs2_val;
  core_types_pkg::xlen_t alu_result;
  logic                  wb_en;
  logic                  retire;
  logic                  running;

  core_fsm u_fsm (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .is_ebreak (dec.is_ebreak),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .inst      (inst),
    .wb_en     (wb_en),
    .retire    (retire),
    .running   (running),
    .halted    (halted)
  );

  inst_decoder u_dec (
    .inst (inst),
    .dec  (dec)
  );

  // write only in WB and only for instructions that produce a result
  register_file u_rf (
    .clk     (clk),
    .raddr_a (dec.rs1),
    .raddr_b (dec.rs2),
    .waddr   (dec.rd),
    .wdata   (alu_result),
    .wen     (wb_en & dec.reg_write),
    .rdata_a (rs1_val),
    .rdata_b (rs2_val),
    .a0      (a0)
  );

  alu u_alu (
    .dec     (dec),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .result  (alu_result)
  );

  cycle_counter u_cnt (
    .clk     (clk),
    .rst     (rst),
    .running (running),
    .retire  (retire),
    .cycles  (cycles),
    .instret (instret)
  );

endmodule

`default_nettype wire

/* source/core_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  is_ebreak,
  input  core_types_pkg::inst_t imem_data,
  output core_types_pkg::pc_t   imem_addr,
  output core_types_pkg::inst_t inst,
  output logic                  wb_en,
  output logic                  retire,
  output logic                  running,
  output logic                  halted
);

  core_ctrl_pkg::fsm_state_t state;
  core_ctrl_pkg::fsm_state_t state_nxt;
  core_types_pkg::pc_t       pc;
  core_types_pkg::inst_t     ir;

  always_comb begin
    state_nxt = state;
    case (state)
      core_ctrl_pkg::S_IDLE:  if (start) state_nxt = core_ctrl_pkg::S_FETCH;
      core_ctrl_pkg::S_FETCH: state_nxt = core_ctrl_pkg::S_EXEC;
      core_ctrl_pkg::S_EXEC: begin
        state_nxt = is_ebreak ? core_ctrl_pkg::S_HALT : core_ctrl_pkg::S_WB;
      end
      core_ctrl_pkg::S_WB:    state_nxt = core_ctrl_pkg::S_FETCH;
      // halt is left only through reset
      default:                state_nxt = core_ctrl_pkg::S_HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= core_ctrl_pkg::S_IDLE;
      pc    <= core_types_pkg::pc_t'(`CORE_RESET_PC);
    end else begin
      state <= state_nxt;
      if (state == core_ctrl_pkg::S_WB) begin
        pc <= pc + core_types_pkg::pc_t'(4);
      end
    end
  end

  // instruction register, loaded from the combinational fetch
  always_ff @(posedge clk) begin
    if (state == core_ctrl_pkg::S_FETCH) begin
      ir <= imem_data;
    end
  end

  assign imem_addr = pc;
  assign inst      = ir;
  assign wb_en     = (state == core_ctrl_pkg::S_WB);
  // ebreak retires in EXEC since it never reaches WB
  assign retire    = wb_en || ((state == core_ctrl_pkg::S_EXEC) && is_ebreak);
  assign running   = (state == core_ctrl_pkg::S_FETCH) || (state == core_ctrl_pkg::S_EXEC) ||
                     wb_en;
  assign halted    = (state == core_ctrl_pkg::S_HALT);

endmodule

`default_nettype wire

/* source/cycle_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 running,
  input  logic                 retire,
  output core_types_pkg::cnt_t cycles,
  output core_types_pkg::cnt_t instret
);

  // both counters stick at all ones
  always_ff @(posedge clk) begin
    if (rst) begin
      cycles <= '0;
    end else if (running && (cycles != '1)) begin
      cycles <= cycles + core_types_pkg::cnt_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      instret <= '0;
    end else if (retire && (instret != '1)) begin
      instret <= instret + core_types_pkg::cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  core_ctrl_pkg::dec_t   dec,
  input  core_types_pkg::xlen_t rs1_val,
  input  core_types_pkg::xlen_t rs2_val,
  output core_types_pkg::xlen_t result
);

  core_types_pkg::xlen_t op_b;

  // immediate forms take operand b from the decoder
  assign op_b = dec.use_imm ? dec.imm : rs2_val;

  always_comb begin
    case (dec.alu_op)
      core_ctrl_pkg::ALU_ADD:    result = rs1_val + op_b;
      core_ctrl_pkg::ALU_SUB:    result = rs1_val - op_b;
      core_ctrl_pkg::ALU_AND:    result = rs1_val & op_b;
      core_ctrl_pkg::ALU_OR:     result = rs1_val | op_b;
      core_ctrl_pkg::ALU_XOR:    result = rs1_val ^ op_b;
      // lui lands here with op_b holding the U immediate
      core_ctrl_pkg::ALU_PASS_B: result = op_b;
      default:                   result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  core_types_pkg::inst_t inst,
  output core_ctrl_pkg::dec_t   dec
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // operation classes
  localparam logic [1:0] CLS_UNKNOWN = 2'd0;
  localparam logic [1:0] CLS_IMM     = 2'd1;
  localparam logic [1:0] CLS_REG     = 2'd2;
  localparam logic [1:0] CLS_LUI     = 2'd3;

  localparam core_types_pkg::inst_t EBREAK_INST = 32'h0010_0073;

  logic [1:0]            cls;
  // {valid, alu_op} for register-register ops
  logic [3:0]            reg_sel;
  core_types_pkg::xlen_t imm_i;
  core_types_pkg::xlen_t imm_u;

  mux_key #(.NR_KEY(3), .KEY_LEN(7), .DATA_LEN(2)) u_cls_mux (
    .key         (inst[6:0]),
    .default_out (CLS_UNKNOWN),
    .lut         ({OPC_OP_IMM, CLS_IMM,
                   OPC_OP,     CLS_REG,
                   OPC_LUI,    CLS_LUI}),
    .out         (cls)
  );

  // key is {funct7, funct3}
  mux_key #(.NR_KEY(5), .KEY_LEN(10), .DATA_LEN(4)) u_op_mux (
    .key         ({inst[31:25], inst[14:12]}),
    .default_out (4'b0000),
    .lut         ({10'b0000000_000, 1'b1, core_ctrl_pkg::ALU_ADD,
                   10'b0100000_000, 1'b1, core_ctrl_pkg::ALU_SUB,
                   10'b0000000_111, 1'b1, core_ctrl_pkg::ALU_AND,
                   10'b0000000_110, 1'b1, core_ctrl_pkg::ALU_OR,
                   10'b0000000_100, 1'b1, core_ctrl_pkg::ALU_XOR}),
    .out         (reg_sel)
  );

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};

  always_comb begin
    dec.rs1       = inst[19:15];
    dec.rs2       = inst[24:20];
    dec.rd        = inst[11:7];
    dec.is_ebreak = (inst == EBREAK_INST);
    dec.imm       = imm_i;
    dec.alu_op    = core_ctrl_pkg::ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.reg_write = 1'b0;
    case (cls)
      CLS_IMM: begin
        dec.use_imm   = 1'b1;
        // only addi among the OP-IMM group
        dec.reg_write = (inst[14:12] == 3'b000);
      end
      CLS_REG: begin
        dec.alu_op    = core_ctrl_pkg::alu_op_t'(reg_sel[2:0]);
        dec.reg_write = reg_sel[3];
      end
      CLS_LUI: begin
        dec.imm       = imm_u;
        dec.alu_op    = core_ctrl_pkg::ALU_PASS_B;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      // unknown opcodes retire as no-ops
      default: dec.reg_write = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module register_file (
  input  logic                      clk,
  input  core_types_pkg::reg_addr_t raddr_a,
  input  core_types_pkg::reg_addr_t raddr_b,
  input  core_types_pkg::reg_addr_t waddr,
  input  core_types_pkg::xlen_t     wdata,
  input  logic                      wen,
  output core_types_pkg::xlen_t     rdata_a,
  output core_types_pkg::xlen_t     rdata_b,
  output core_types_pkg::xlen_t     a0
);

  localparam int NR_REGS = 1 << `CORE_RADDR_W;
  localparam core_types_pkg::reg_addr_t A0_IDX = 10;

  core_types_pkg::xlen_t regs [NR_REGS];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads zero whatever was written to it
  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

  assign a0 = regs[A0_IDX];

endmodule

`default_nettype wire

/* source/mux_key.sv */
`timescale 1ns/1ps
`default_nettype none

// keyed selector
// lut holds NR_KEY pairs of {key, data}, the first pair in the upper bits
module mux_key #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  logic [KEY_LEN-1:0]                    key,
  input  logic [DATA_LEN-1:0]                   default_out,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0]  lut,
  output logic [DATA_LEN-1:0]                   out
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  logic [DATA_LEN-1:0] lut_out;
  logic                hit;

  always_comb begin
    logic [PAIR_LEN-1:0] pair;
    logic                match;
    lut_out = '0;
    hit     = 1'b0;
    for (int n = 0; n < NR_KEY; n++) begin
      pair  = lut[n*PAIR_LEN +: PAIR_LEN];
      match = (key == pair[PAIR_LEN-1:DATA_LEN]);
      // several matching keys OR their data together
      lut_out = lut_out | ({DATA_LEN{match}} & pair[DATA_LEN-1:0]);
      hit     = hit | match;
    end
  end

  // no key matched, fall back to the default
  assign out = hit ? lut_out : default_out;

endmodule

`default_nettype wire

/* source/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

  // sequencer states, one instruction is FETCH -> EXEC -> WB
  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC,
    S_WB,
    S_HALT
  } fsm_state_t;

  // alu operations
  // ALU_PASS_B forwards operand b, used by lui
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_t;

  // decoded instruction, shared by decoder, alu and register file
  typedef struct packed {
    core_types_pkg::reg_addr_t rs1;
    core_types_pkg::reg_addr_t rs2;
    core_types_pkg::reg_addr_t rd;
    // sign-extended I or U immediate
    core_types_pkg::xlen_t     imm;
    alu_op_t                   alu_op;
    // operand b from imm instead of rs2
    logic                      use_imm;
    logic                      reg_write;
    logic                      is_ebreak;
  } dec_t;

endpackage

`default_nettype wire

/* source/core_types_pkg.sv */
`default_nettype none

`include "core_settings.svh"

package core_types_pkg;

  // register data and alu values
  typedef logic [`CORE_XLEN-1:0] xlen_t;

  // architectural register index
  typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

  // raw 32-bit instruction word, no compressed forms
  typedef logic [31:0] inst_t;

  // fetch address, same width as the data path
  typedef logic [`CORE_XLEN-1:0] pc_t;

  // performance counter value
  typedef logic [`CORE_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

/* include/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// core sizing for the RV64I subset

// data path width
`define CORE_XLEN 64

// register address width, 32 architectural registers
`define CORE_RADDR_W 5

// width of the cycle and instret counters
`define CORE_CNT_W 32

// first fetch address after reset
`define CORE_RESET_PC 64'h0000_0000_0000_0000

`endif
